// ==== common/vdc_pkg.sv ====
//##########################################################################
// VDC shared definitions
// widths, register numbers, row latch size and the enums used by the
// video RAM interface
//##########################################################################

package vdc_pkg;

	localparam int RAM_ADDR_BITS = 16;

	typedef logic [RAM_ADDR_BITS-1:0] vaddr_t;  // video ram byte address
	typedef logic [7:0]               vbyte_t;  // ram data or cpu bus byte
	typedef logic [5:0]               regnum_t; // internal register number

	// cpu memory actions, copy takes a read and a write per word
	typedef enum logic [2:0] {
		CA_NONE,
		CA_READ,
		CA_WRITE,
		CA_FILL,
		CA_COPY0,
		CA_COPY1
	} cpu_action_t;

	// fetch type of the ram cycle in flight
	typedef enum logic [2:0] {
		RA_NONE,
		RA_CHAR,
		RA_SCRN,
		RA_ATTR,
		RA_CPU
	} ram_action_t;

	localparam vbyte_t ROW_BUF_LEN  = 8'd16;             // entries per row latch
	localparam int     ROW_IDX_BITS = $clog2(ROW_BUF_LEN);

	localparam regnum_t R_HT    = 6'd0;  // horizontal total
	localparam regnum_t R_HD    = 6'd1;  // horizontal displayed
	localparam regnum_t R_VT    = 6'd4;  // vertical total, in rows
	localparam regnum_t R_CTV   = 6'd9;  // lines per character row
	localparam regnum_t R_DS_HI = 6'd12; // display start
	localparam regnum_t R_DS_LO = 6'd13;
	localparam regnum_t R_UA_HI = 6'd18; // update address
	localparam regnum_t R_UA_LO = 6'd19;
	localparam regnum_t R_AA_HI = 6'd20; // attribute start
	localparam regnum_t R_AA_LO = 6'd21;
	localparam regnum_t R_COPY  = 6'd24; // bit 7 selects copy
	localparam regnum_t R_AI    = 6'd27; // address increment per row
	localparam regnum_t R_CB    = 6'd28; // character base in bits 7:5
	localparam regnum_t R_WC    = 6'd30; // word count
	localparam regnum_t R_DA    = 6'd31; // data
	localparam regnum_t R_BA_HI = 6'd32; // block start address
	localparam regnum_t R_BA_LO = 6'd33;
	localparam regnum_t R_DRR   = 6'd36; // refresh cycles per line

endpackage

// ==== vdc_ramiface/vdc_ram.sv ====
//##########################################################################
// VDC video RAM
// single-port 64K x 8 with synchronous write and registered read
//##########################################################################

module vdc_ram (
	input  logic            clk,
	input  logic            rd,
	input  logic            we,
	input  vdc_pkg::vaddr_t addr,
	input  vdc_pkg::vbyte_t dai,
	output vdc_pkg::vbyte_t dao
);
	import vdc_pkg::*;

	vbyte_t mem [2**RAM_ADDR_BITS];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= dai;
		if (rd)
			dao <= mem[addr]; // valid in the end_col cycle
	end

endmodule

// ==== vdc_ramiface/vdc_ramiface.sv ====
//##########################################################################
// VDC video RAM interface
// one ram cycle per column, shared by character, refresh, screen and
// attribute fetches and the cpu read, write, fill and copy actions
//##########################################################################

module vdc_ramiface (
	input  logic             clk,
	input  logic             reset,
	input  logic             bus_access,
	input  logic             bus_we,
	input  vdc_pkg::regnum_t reg_sel,
	input  vdc_pkg::vbyte_t  db_in,
	input  vdc_pkg::vbyte_t  reg_ht,
	input  vdc_pkg::vbyte_t  reg_hd,
	input  vdc_pkg::vbyte_t  reg_ai,
	input  vdc_pkg::vaddr_t  reg_ds,
	input  vdc_pkg::vaddr_t  reg_aa,
	input  logic [2:0]       reg_cb,
	input  logic [3:0]       reg_drr,
	input  logic             reg_copy,
	input  logic             enable0,
	input  logic             enable1,
	input  logic             new_col,
	input  logic             end_col,
	input  logic             new_line,
	input  logic             new_row,
	input  logic             new_frame,
	input  vdc_pkg::vbyte_t  col,
	input  vdc_pkg::vbyte_t  row,
	input  logic [4:0]       line,
	output logic             busy,
	output vdc_pkg::vaddr_t  reg_ua,
	output vdc_pkg::vaddr_t  reg_ba,
	output vdc_pkg::vbyte_t  reg_wc,
	output vdc_pkg::vbyte_t  reg_da,
	output vdc_pkg::vbyte_t  char_byte,
	output vdc_pkg::vbyte_t  attr_byte
);
	import vdc_pkg::*;

	cpu_action_t cpu_action;
	ram_action_t ram_action;
	ram_action_t next_action;

	logic   ram_rd;
	logic   ram_we;
	vaddr_t ram_addr;
	vbyte_t ram_di;
	vbyte_t ram_do;

	vbyte_t scrn_buf [2][ROW_BUF_LEN];
	vbyte_t attr_buf [2][ROW_BUF_LEN];
	logic   row_buf;   // latch shown in the current row
	logic   disp_buf;
	vaddr_t scrn_addr; // row being fetched
	vaddr_t attr_addr;
	vaddr_t stride;
	vbyte_t si;        // screen bytes fetched this row
	vbyte_t ai;
	vbyte_t rfsh_addr;
	logic [3:0] rfsh_left;
	logic [3:0] rfsh_avail;
	vbyte_t wda;       // write and fill data
	vbyte_t cda;       // copy data
	vbyte_t wc;
	logic [ROW_IDX_BITS-1:0] col_idx;
	logic   issue;
	logic   en_char;
	logic   en_rfsh;
	logic   en_scac;
	logic   scrn_due;
	logic   attr_due;

	vdc_ram i_ram (
		.clk  (clk),
		.rd   (ram_rd),
		.we   (ram_we),
		.addr (ram_addr),
		.dai  (ram_di),
		.dao  (ram_do)
	);

	assign busy     = cpu_action != CA_NONE;
	assign issue    = enable0 & new_col;
	assign disp_buf = new_row ? ~row_buf : row_buf; // swap already counts in column 0
	assign col_idx  = col[ROW_IDX_BITS-1:0];
	assign stride   = vaddr_t'(reg_hd) + vaddr_t'(reg_ai);

	// row 0 only fetches, so its latch shows from row 1 on
	assign en_char    = row != 8'd0 && col < reg_hd;
	assign rfsh_avail = new_line ? reg_drr : rfsh_left;
	assign en_rfsh    = col >= reg_hd && rfsh_avail != 4'd0;
	assign en_scac    = col >= 8'd2 && {1'b0, col} + 9'd2 < {1'b0, reg_ht};
	assign scrn_due   = en_scac && si < reg_hd && si < ROW_BUF_LEN;
	assign attr_due   = en_scac && ai < reg_hd && ai < ROW_BUF_LEN;

	// arbitration, the ram samples these at the end of the new_col cycle
	always_comb begin
		ram_rd      = 1'b0;
		ram_we      = 1'b0;
		ram_addr    = '0;
		ram_di      = wda;
		next_action = RA_NONE;
		if (issue) begin
			if (en_char) begin
				next_action = RA_CHAR;
				ram_rd      = 1'b1;
				ram_addr    = {reg_cb, scrn_buf[disp_buf][col_idx], line};
			end else if (en_rfsh) begin
				ram_rd   = 1'b1;               // data is dropped
				ram_addr = {rfsh_addr, rfsh_addr};
			end else if (scrn_due) begin
				next_action = RA_SCRN;
				ram_rd      = 1'b1;
				ram_addr    = scrn_addr + vaddr_t'(si);
			end else if (attr_due) begin
				next_action = RA_ATTR;
				ram_rd      = 1'b1;
				ram_addr    = attr_addr + vaddr_t'(ai);
			end else if (cpu_action != CA_NONE) begin
				next_action = RA_CPU;
				case (cpu_action)
					CA_READ: begin
						ram_rd   = 1'b1;
						ram_addr = reg_ua;
					end
					CA_WRITE, CA_FILL: begin
						ram_we   = 1'b1;
						ram_addr = reg_ua;
					end
					CA_COPY0: begin
						ram_rd   = 1'b1;
						ram_addr = reg_ba;
					end
					CA_COPY1: begin
						ram_we   = 1'b1;
						ram_addr = reg_ua;
						ram_di   = cda;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_action <= CA_NONE;
			ram_action <= RA_NONE;
			reg_ua     <= '0;
			reg_ba     <= '0;
			reg_wc     <= '0;
			reg_da     <= '0;
			wda        <= '0;
			cda        <= '0;
			wc         <= '0;
			row_buf    <= 1'b0;
			scrn_addr  <= '0;
			attr_addr  <= '0;
			si         <= '0;
			ai         <= '0;
			rfsh_addr  <= '0;
			rfsh_left  <= '0;
			char_byte  <= '0;
			attr_byte  <= '0;
			for (int i = 0; i < ROW_BUF_LEN; i++) begin
				scrn_buf[0][i] <= '0;
				scrn_buf[1][i] <= '0;
				attr_buf[0][i] <= '0;
				attr_buf[1][i] <= '0;
			end
		end else begin
			if (issue) begin
				ram_action <= next_action;
				rfsh_left  <= en_rfsh ? rfsh_avail - 4'd1 : rfsh_avail;
				if (en_rfsh)
					rfsh_addr <= rfsh_addr + 8'd1;
				if (new_row) begin
					row_buf   <= ~row_buf;
					si        <= '0;
					ai        <= '0;
					scrn_addr <= new_frame ? reg_ds : scrn_addr + stride;
					attr_addr <= new_frame ? reg_aa : attr_addr + stride;
				end
			end

			if (enable1 && end_col) begin
				case (ram_action)
					RA_CHAR: begin
						char_byte <= ram_do;
						attr_byte <= attr_buf[row_buf][col_idx];
					end
					RA_SCRN: begin
						scrn_buf[~row_buf][si[ROW_IDX_BITS-1:0]] <= ram_do;
						si <= si + 8'd1;
					end
					RA_ATTR: begin
						attr_buf[~row_buf][ai[ROW_IDX_BITS-1:0]] <= ram_do;
						ai <= ai + 8'd1;
					end
					RA_CPU: begin
						case (cpu_action)
							CA_READ: begin
								reg_da     <= ram_do;
								cpu_action <= CA_NONE;
							end
							CA_WRITE: begin
								reg_ua     <= reg_ua + 16'd1;
								cpu_action <= CA_READ; // reload da from the next address
							end
							CA_FILL: begin
								reg_ua     <= reg_ua + 16'd1;
								wc         <= wc - 8'd1;
								cpu_action <= (wc == 8'd1) ? CA_NONE : CA_FILL;
							end
							CA_COPY0: begin
								cda        <= ram_do;
								reg_ba     <= reg_ba + 16'd1;
								cpu_action <= CA_COPY1;
							end
							CA_COPY1: begin
								reg_ua     <= reg_ua + 16'd1;
								wc         <= wc - 8'd1;
								cpu_action <= (wc == 8'd1) ? CA_NONE : CA_COPY0;
							end
							default: ;
						endcase
					end
					default: ;
				endcase
			end

			if (bus_access) begin
				if (!bus_we) begin
					if (reg_sel == R_DA) begin
						reg_ua     <= reg_ua + 16'd1;
						cpu_action <= CA_READ;
					end
				end else begin
					case (reg_sel)
						R_UA_HI: begin
							reg_ua[15:8] <= db_in;
							cpu_action   <= CA_READ;
						end
						R_UA_LO: begin
							reg_ua[7:0] <= db_in;
							cpu_action  <= CA_READ;
						end
						R_WC: begin
							reg_wc     <= db_in;
							wc         <= db_in;
							cpu_action <= reg_copy ? CA_COPY0 : CA_FILL;
						end
						R_DA: begin
							wda        <= db_in;
							cpu_action <= CA_WRITE;
						end
						R_BA_HI: reg_ba[15:8] <= db_in;
						R_BA_LO: reg_ba[7:0]  <= db_in;
						default: ;
					endcase
				end
			end
		end
	end

endmodule

// ==== src/vdc_regs.sv ====
//##########################################################################
// VDC register file
// address latch, display format registers and cpu read-back
//##########################################################################

module vdc_regs (
	input  logic             clk,
	input  logic             reset,
	input  logic             cs,
	input  logic             rs,
	input  logic             we,
	input  vdc_pkg::vbyte_t  db_in,
	input  logic             busy,
	input  vdc_pkg::vaddr_t  reg_ua,
	input  vdc_pkg::vaddr_t  reg_ba,
	input  vdc_pkg::vbyte_t  reg_wc,
	input  vdc_pkg::vbyte_t  reg_da,
	output vdc_pkg::vbyte_t  db_out,
	output logic             bus_access,
	output logic             bus_we,
	output vdc_pkg::regnum_t reg_sel,
	output vdc_pkg::vbyte_t  reg_ht,
	output vdc_pkg::vbyte_t  reg_hd,
	output vdc_pkg::vbyte_t  reg_vt,
	output vdc_pkg::vbyte_t  reg_ai,
	output logic [4:0]       reg_ctv,
	output vdc_pkg::vaddr_t  reg_ds,
	output vdc_pkg::vaddr_t  reg_aa,
	output logic [2:0]       reg_cb,
	output logic [3:0]       reg_drr,
	output logic             reg_copy
);
	import vdc_pkg::*;

	vbyte_t read_mux;

	assign bus_access = cs & rs; // data port access, one cycle
	assign bus_we     = we;

	always_comb begin
		case (reg_sel)
			R_HT:    read_mux = reg_ht;
			R_HD:    read_mux = reg_hd;
			R_VT:    read_mux = reg_vt;
			R_CTV:   read_mux = {3'b000, reg_ctv};
			R_DS_HI: read_mux = reg_ds[15:8];
			R_DS_LO: read_mux = reg_ds[7:0];
			R_UA_HI: read_mux = reg_ua[15:8];
			R_UA_LO: read_mux = reg_ua[7:0];
			R_AA_HI: read_mux = reg_aa[15:8];
			R_AA_LO: read_mux = reg_aa[7:0];
			R_COPY:  read_mux = {reg_copy, 7'd0};
			R_AI:    read_mux = reg_ai;
			R_CB:    read_mux = {reg_cb, 5'd0};
			R_WC:    read_mux = reg_wc;
			R_DA:    read_mux = reg_da;
			R_BA_HI: read_mux = reg_ba[15:8];
			R_BA_LO: read_mux = reg_ba[7:0];
			R_DRR:   read_mux = {4'd0, reg_drr};
			default: read_mux = 8'hff; // unimplemented registers
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_sel  <= '0;
			reg_ht   <= '0;
			reg_hd   <= '0;
			reg_vt   <= '0;
			reg_ai   <= '0;
			reg_ctv  <= '0;
			reg_ds   <= '0;
			reg_aa   <= '0;
			reg_cb   <= '0;
			reg_drr  <= '0;
			reg_copy <= 1'b0;
			db_out   <= '0;
		end else if (cs) begin
			if (!rs && we) begin
				reg_sel <= db_in[5:0];
			end else if (rs && we) begin
				case (reg_sel)
					R_HT:    reg_ht       <= db_in;
					R_HD:    reg_hd       <= db_in;
					R_VT:    reg_vt       <= db_in;
					R_CTV:   reg_ctv      <= db_in[4:0];
					R_DS_HI: reg_ds[15:8] <= db_in;
					R_DS_LO: reg_ds[7:0]  <= db_in;
					R_AA_HI: reg_aa[15:8] <= db_in;
					R_AA_LO: reg_aa[7:0]  <= db_in;
					R_COPY:  reg_copy     <= db_in[7];
					R_AI:    reg_ai       <= db_in;
					R_CB:    reg_cb       <= db_in[7:5];
					R_DRR:   reg_drr      <= db_in[3:0];
					default: ;            // ua, wc, da and ba live in the ram interface
				endcase
			end
			if (!we)
				db_out <= rs ? read_mux : {busy, 7'd0}; // status has busy in bit 7
		end
	end

endmodule

// ==== src/vdc_timing.sv ====
//##########################################################################
// VDC timing generator
// two-phase column enables and the column, line and row counters,
// with strobes on the first column of each wrap
//##########################################################################

module vdc_timing (
	input  logic            clk,
	input  logic            reset,
	input  vdc_pkg::vbyte_t reg_ht,
	input  vdc_pkg::vbyte_t reg_hd,
	input  vdc_pkg::vbyte_t reg_vt,
	input  logic [4:0]      reg_ctv,
	output logic            enable0,
	output logic            enable1,
	output logic            new_col,
	output logic            end_col,
	output logic            new_line,
	output logic            new_row,
	output logic            new_frame,
	output vdc_pkg::vbyte_t col,
	output vdc_pkg::vbyte_t row,
	output logic [4:0]      line
);
	import vdc_pkg::*;

	logic   phase;
	vbyte_t col_last;

	// never wrap inside the displayed columns
	assign col_last = (reg_ht < reg_hd) ? reg_hd : reg_ht;

	assign enable0 = ~phase;
	assign enable1 = phase;
	assign new_col = enable0;  // ram cycle issue
	assign end_col = enable1;  // ram cycle completion

	assign new_line  = new_col && col == 8'd0;
	assign new_row   = new_line && line == 5'd0;
	assign new_frame = new_row && row == 8'd0;

	// counters step at end_col, so the next new_col sees the new position
	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= 1'b0;
			col   <= '0;
			line  <= '0;
			row   <= '0;
		end else begin
			phase <= ~phase;
			if (end_col) begin
				if (col >= col_last) begin
					col <= '0;
					if (line >= reg_ctv) begin
						line <= '0;
						if (row >= reg_vt)
							row <= '0;
						else
							row <= row + 8'd1;
					end else begin
						line <= line + 5'd1;
					end
				end else begin
					col <= col + 8'd1;
				end
			end
		end
	end

endmodule

// ==== src/vdc_top.sv ====
//##########################################################################
// VDC memory subsystem top
// cpu register bus in, fetched character and attribute bytes out
//##########################################################################

module vdc_top (
	input  logic            clk,
	input  logic            reset,
	input  logic            cs,
	input  logic            rs,
	input  logic            we,
	input  vdc_pkg::vbyte_t db_in,
	output vdc_pkg::vbyte_t db_out,
	output vdc_pkg::vbyte_t char_byte,
	output vdc_pkg::vbyte_t attr_byte,
	output vdc_pkg::vbyte_t col,
	output logic [4:0]      line,
	output vdc_pkg::vbyte_t row
);
	import vdc_pkg::*;

	logic       bus_access;
	logic       bus_we;
	regnum_t    reg_sel;
	vbyte_t     reg_ht;
	vbyte_t     reg_hd;
	vbyte_t     reg_vt;
	vbyte_t     reg_ai;
	logic [4:0] reg_ctv;
	vaddr_t     reg_ds;
	vaddr_t     reg_aa;
	logic [2:0] reg_cb;
	logic [3:0] reg_drr;
	logic       reg_copy;
	logic       busy;
	vaddr_t     reg_ua;
	vaddr_t     reg_ba;
	vbyte_t     reg_wc;
	vbyte_t     reg_da;
	logic       enable0;
	logic       enable1;
	logic       new_col;
	logic       end_col;
	logic       new_line;
	logic       new_row;
	logic       new_frame;

	vdc_regs i_regs (
		.clk        (clk),
		.reset      (reset),
		.cs         (cs),
		.rs         (rs),
		.we         (we),
		.db_in      (db_in),
		.busy       (busy),
		.reg_ua     (reg_ua),
		.reg_ba     (reg_ba),
		.reg_wc     (reg_wc),
		.reg_da     (reg_da),
		.db_out     (db_out),
		.bus_access (bus_access),
		.bus_we     (bus_we),
		.reg_sel    (reg_sel),
		.reg_ht     (reg_ht),
		.reg_hd     (reg_hd),
		.reg_vt     (reg_vt),
		.reg_ai     (reg_ai),
		.reg_ctv    (reg_ctv),
		.reg_ds     (reg_ds),
		.reg_aa     (reg_aa),
		.reg_cb     (reg_cb),
		.reg_drr    (reg_drr),
		.reg_copy   (reg_copy)
	);

	vdc_timing i_timing (
		.clk       (clk),
		.reset     (reset),
		.reg_ht    (reg_ht),
		.reg_hd    (reg_hd),
		.reg_vt    (reg_vt),
		.reg_ctv   (reg_ctv),
		.enable0   (enable0),
		.enable1   (enable1),
		.new_col   (new_col),
		.end_col   (end_col),
		.new_line  (new_line),
		.new_row   (new_row),
		.new_frame (new_frame),
		.col       (col),
		.row       (row),
		.line      (line)
	);

	vdc_ramiface i_ramiface (
		.clk        (clk),
		.reset      (reset),
		.bus_access (bus_access),
		.bus_we     (bus_we),
		.reg_sel    (reg_sel),
		.db_in      (db_in),
		.reg_ht     (reg_ht),
		.reg_hd     (reg_hd),
		.reg_ai     (reg_ai),
		.reg_ds     (reg_ds),
		.reg_aa     (reg_aa),
		.reg_cb     (reg_cb),
		.reg_drr    (reg_drr),
		.reg_copy   (reg_copy),
		.enable0    (enable0),
		.enable1    (enable1),
		.new_col    (new_col),
		.end_col    (end_col),
		.new_line   (new_line),
		.new_row    (new_row),
		.new_frame  (new_frame),
		.col        (col),
		.row        (row),
		.line       (line),
		.busy       (busy),
		.reg_ua     (reg_ua),
		.reg_ba     (reg_ba),
		.reg_wc     (reg_wc),
		.reg_da     (reg_da),
		.char_byte  (char_byte),
		.attr_byte  (attr_byte)
	);

endmodule

// ==== verif/vdc_clkgen.sv ====
//##########################################################################
// VDC testbench clock and reset
// 10 ns clock, reset held high for the first 16 rising edges
//##########################################################################

module vdc_clkgen (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk); // release away from the sampling edge
		reset = 1'b0;
	end

endmodule

// ==== verif/vdc_tb.sv ====
//##########################################################################
// VDC testbench
// cpu register bus stimulus, shadow model of the video ram, checks of
// the memory actions and of the per-column character and attribute bytes
//##########################################################################

module vdc_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import vdc_pkg::*;

	localparam logic [31:0] SEED         = 32'h89ed_59cd;
	localparam int          IDLE_POLLS   = 2000;
	localparam int          FRAME_CYCLES = 4000; // a frame is under 1000 cycles
	localparam int          RESET_LIMIT  = 100;
	localparam vbyte_t      HT           = 8'd14;
	localparam vbyte_t      HD           = 8'd8;
	localparam vbyte_t      VT           = 8'd3;
	localparam vbyte_t      CTV          = 8'd7;
	localparam vbyte_t      DRR          = 8'd2;
	localparam logic [2:0]  CB           = 3'd1;
	localparam vaddr_t      FONT         = {CB, 13'd0}; // character base times 8K
	localparam vaddr_t      DS           = 16'h1000;
	localparam vaddr_t      AA           = 16'h1800;
	localparam int          TEXT_ROWS    = 4;
	localparam vaddr_t      SEQ_BASE     = 16'h4000;
	localparam vaddr_t      FILL_BASE    = 16'h5000;
	localparam vaddr_t      COPY_DST     = 16'h6000;
	localparam vaddr_t      LIVE_FILL    = 16'h7000;
	localparam int          SEQ_LEN      = 12;
	localparam int          FILL_LEN     = 20;
	localparam int          LIVE_LEN     = 40;

	logic       clk;
	logic       reset;
	logic       cs;
	logic       rs;
	logic       we;
	vbyte_t     db_in;
	vbyte_t     db_out;
	vbyte_t     char_byte;
	vbyte_t     attr_byte;
	vbyte_t     col;
	logic [4:0] line;
	vbyte_t     row;

	vbyte_t     shadow [65536]; // expected ram contents of the written cells
	vaddr_t     ua_model;
	vaddr_t     ba_model;
	vbyte_t     last_da;        // fill data
	logic       check_on;
	int         fetch_checks;
	int         frame_count;
	int         col_cycles;
	vbyte_t     prev_col;
	vbyte_t     prev_row;
	logic [4:0] prev_line;
	vbyte_t     code;

	vdc_clkgen i_clkgen (
		.clk   (clk),
		.reset (reset)
	);

	vdc_top i_dut (
		.clk       (clk),
		.reset     (reset),
		.cs        (cs),
		.rs        (rs),
		.we        (we),
		.db_in     (db_in),
		.db_out    (db_out),
		.char_byte (char_byte),
		.attr_byte (attr_byte),
		.col       (col),
		.line      (line),
		.row       (row)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic expect_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp)
		else abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic bus_write(input logic sel, input vbyte_t data);
		@(negedge clk);
		cs    = 1'b1;
		rs    = sel;
		we    = 1'b1;
		db_in = data;
		@(negedge clk);
		cs = 1'b0;
		we = 1'b0;
	endtask

	task automatic bus_read(input logic sel, output vbyte_t data);
		@(negedge clk);
		cs = 1'b1;
		rs = sel;
		we = 1'b0;
		@(negedge clk);
		cs   = 1'b0;
		data = db_out; // registered at the edge in between
	endtask

	task automatic reg_write(input regnum_t num, input vbyte_t data);
		bus_write(1'b0, {2'b00, num});
		bus_write(1'b1, data);
	endtask

	task automatic reg_read(input regnum_t num, output vbyte_t data);
		bus_write(1'b0, {2'b00, num});
		bus_read(1'b1, data);
	endtask

	task automatic read_pair(input regnum_t hi, input regnum_t lo, output vaddr_t value);
		vbyte_t h;
		vbyte_t l;
		reg_read(hi, h);
		reg_read(lo, l);
		value = {h, l};
	endtask

	// poll status until busy (bit 7) drops
	task automatic wait_idle();
		vbyte_t status;
		int     polls;
		polls  = 0;
		status = 8'h80;
		while (status[7]) begin
			if (polls == IDLE_POLLS)
				abort_run("timeout: busy stayed high while polling status");
			bus_read(1'b0, status);
			polls++;
		end
	endtask

	task automatic set_ua(input vaddr_t addr);
		reg_write(R_UA_HI, addr[15:8]);
		wait_idle();
		reg_write(R_UA_LO, addr[7:0]);
		wait_idle();
		ua_model = addr;
	endtask

	task automatic set_ba(input vaddr_t addr);
		reg_write(R_BA_HI, addr[15:8]);
		reg_write(R_BA_LO, addr[7:0]);
		ba_model = addr;
	endtask

	task automatic write_da(input vbyte_t data);
		reg_write(R_DA, data);
		wait_idle();
		shadow[ua_model] = data;
		ua_model         = ua_model + 16'd1;
		last_da          = data;
	endtask

	// each da read returns the loaded byte and moves on to the next address
	task automatic read_da_check();
		vbyte_t data;
		reg_read(R_DA, data);
		wait_idle();
		expect_value("da", data, shadow[ua_model]);
		ua_model = ua_model + 16'd1;
	endtask

	task automatic verify_range(input vaddr_t start, input int len);
		set_ua(start);
		for (int i = 0; i < len; i++)
			read_da_check();
	endtask

	task automatic check_ua();
		vaddr_t value;
		read_pair(R_UA_HI, R_UA_LO, value);
		expect_value("ua", value, ua_model);
	endtask

	task automatic check_ba();
		vaddr_t value;
		read_pair(R_BA_HI, R_BA_LO, value);
		expect_value("ba", value, ba_model);
	endtask

	task automatic run_fill(input vbyte_t len);
		vbyte_t wc;
		reg_write(R_WC, len);
		wait_idle();
		for (int i = 0; i < int'(len); i++) begin
			shadow[ua_model] = last_da;
			ua_model         = ua_model + 16'd1;
		end
		reg_read(R_WC, wc);
		expect_value("wc", wc, len);
	endtask

	task automatic run_copy(input vbyte_t len);
		reg_write(R_WC, len);
		wait_idle();
		for (int i = 0; i < int'(len); i++) begin
			shadow[ua_model] = shadow[ba_model];
			ua_model         = ua_model + 16'd1;
			ba_model         = ba_model + 16'd1;
		end
	endtask

	// every text row holds the same codes and attributes
	task automatic load_display_memory();
		vbyte_t glyph;
		set_ua(DS);
		for (int i = 0; i < TEXT_ROWS * int'(HD); i++)
			write_da((i < int'(HD)) ? vbyte_t'($urandom) : shadow[DS + vaddr_t'(i % int'(HD))]);
		set_ua(AA);
		for (int i = 0; i < TEXT_ROWS * int'(HD); i++)
			write_da((i < int'(HD)) ? vbyte_t'($urandom) : shadow[AA + vaddr_t'(i % int'(HD))]);
		for (int c = 0; c < int'(HD); c++) begin
			glyph = shadow[DS + vaddr_t'(c)];
			set_ua(FONT + vaddr_t'(glyph) * 16'd32); // 32 bytes per glyph
			for (int l = 0; l <= int'(CTV); l++)
				write_da(vbyte_t'($urandom));
		end
	endtask

	task automatic wait_frames(input int frames);
		int target;
		int cycles;
		target = frame_count + frames;
		cycles = 0;
		while (frame_count < target) begin
			if (cycles == frames * FRAME_CYCLES)
				abort_run("timeout: no new frame started");
			@(negedge clk);
			cycles++;
		end
	endtask

	// col runs 0 to HT, line 0 to CTV and row 0 to VT
	task automatic check_position();
		vbyte_t     exp_col;
		logic [4:0] exp_line;
		vbyte_t     exp_row;
		exp_col  = (prev_col == HT) ? 8'd0 : prev_col + 8'd1;
		exp_line = prev_line;
		exp_row  = prev_row;
		if (exp_col == 8'd0) begin
			exp_line = (prev_line == CTV[4:0]) ? 5'd0 : prev_line + 5'd1;
			if (exp_line == 5'd0)
				exp_row = (prev_row == VT) ? 8'd0 : prev_row + 8'd1;
		end
		expect_value("col", col, exp_col);
		expect_value("line", line, exp_line);
		expect_value("row", row, exp_row);
	endtask

	// fetched bytes only move when the column steps
	fetch_stable: assert property (@(posedge clk) disable iff (reset)
		(col == $past(col)) |-> (char_byte == $past(char_byte) &&
			attr_byte == $past(attr_byte)))
	else abort_run("char_byte or attr_byte changed without a column step");

	// fetch results and the new position are in place once col steps
	always @(negedge clk) begin
		if (reset) begin
			prev_col     = '0;
			prev_line    = '0;
			prev_row     = '0;
			fetch_checks = 0;
			frame_count  = 0;
			col_cycles   = 0;
		end else begin
			col_cycles++;
			if (check_on && col_cycles > 2)
				abort_run("col did not step within two clock cycles");
			if (col != prev_col) begin
				if (check_on) begin
					assert (col_cycles == 2)
					else abort_run("col stepped before two clock cycles had passed");
					check_position();
					if (prev_row != 8'd0 && prev_col < HD) begin
						code = shadow[DS + vaddr_t'(prev_col)];
						expect_value("char_byte", char_byte,
							shadow[FONT + vaddr_t'(code) * 16'd32 + vaddr_t'(prev_line)]);
						expect_value("attr_byte", attr_byte, shadow[AA + vaddr_t'(prev_col)]);
						fetch_checks++;
					end
				end
				col_cycles = 0;
				if (row == 8'd0 && prev_row != 8'd0)
					frame_count++;
				prev_col  = col;
				prev_line = line;
				prev_row  = row;
			end
		end
	end

	initial begin
		vbyte_t data;
		vaddr_t addr;
		int     count;
		int     cycles;
		cs       = 1'b0;
		rs       = 1'b0;
		we       = 1'b0;
		db_in    = '0;
		check_on = 1'b0;
		ua_model = '0;
		ba_model = '0;
		last_da  = '0;
		void'($urandom(SEED));

		cycles = 0;
		while (reset !== 1'b0) begin
			if (cycles == RESET_LIMIT)
				abort_run("timeout: reset was never released");
			@(negedge clk);
			cycles++;
		end

		// reset state
		bus_read(1'b0, data);
		expect_value("busy", data[7], 1'b0);
		read_pair(R_UA_HI, R_UA_LO, addr);
		expect_value("ua", addr, 16'h0000);
		read_pair(R_BA_HI, R_BA_LO, addr);
		expect_value("ba", addr, 16'h0000);
		reg_read(R_WC, data);
		expect_value("wc", data, 8'h00);
		reg_read(R_DA, data);
		expect_value("da", data, 8'h00);
		wait_idle(); // the da read starts a reload

		// sequential writes, then read back
		set_ua(SEQ_BASE);
		for (int i = 0; i < SEQ_LEN; i++)
			write_da(vbyte_t'($urandom));
		check_ua();
		set_ua(SEQ_BASE);
		write_da(shadow[SEQ_BASE]);
		read_da_check(); // da now holds the byte after the write
		verify_range(SEQ_BASE, SEQ_LEN);
		check_ua();

		// fill with the last written byte
		set_ua(FILL_BASE);
		write_da(vbyte_t'($urandom));
		run_fill(vbyte_t'(FILL_LEN));
		check_ua();
		verify_range(FILL_BASE, FILL_LEN + 1);

		// block copy
		reg_write(R_COPY, 8'h80);
		set_ba(SEQ_BASE);
		set_ua(COPY_DST);
		run_copy(vbyte_t'(SEQ_LEN));
		check_ua();
		check_ba();
		reg_write(R_COPY, 8'h00);
		verify_range(COPY_DST, SEQ_LEN);

		// small text screen
		load_display_memory();
		reg_write(R_HT, HT);
		reg_write(R_HD, HD);
		reg_write(R_VT, VT);
		reg_write(R_CTV, CTV);
		reg_write(R_AI, 8'd0);
		reg_write(R_DRR, DRR);
		reg_write(R_CB, {CB, 5'd0});
		reg_write(R_DS_HI, DS[15:8]);
		reg_write(R_DS_LO, DS[7:0]);
		reg_write(R_AA_HI, AA[15:8]);
		reg_write(R_AA_LO, AA[7:0]);
		wait_frames(2);
		check_on = 1'b1;
		count    = fetch_checks;
		wait_frames(1);
		assert (fetch_checks > count)
		else abort_run("no character fetch was seen in a whole frame");

		// cpu fill competing with the display fetches
		set_ua(LIVE_FILL);
		write_da(vbyte_t'($urandom));
		run_fill(vbyte_t'(LIVE_LEN));
		check_ua();
		count = fetch_checks;
		wait_frames(2);
		assert (fetch_checks > count)
		else abort_run("character fetches stopped after the cpu fill");
		verify_range(LIVE_FILL, LIVE_LEN + 1);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== files.f ====
common/vdc_pkg.sv
vdc_ramiface/vdc_ram.sv
vdc_ramiface/vdc_ramiface.sv
src/vdc_regs.sv
src/vdc_timing.sv
src/vdc_top.sv
verif/vdc_clkgen.sv
verif/vdc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the VDC testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module vdc_tb -f files.f -o vdc_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/vdc_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit $status
fi
exit 0
